// ==== design/mem_axi_pkg.sv ====
package mem_axi_pkg;

    localparam int data_w = 32;          // Memory word width in bits.
    localparam int addr_w = 32;          // Byte address width.
    localparam int strb_w = data_w / 8;  // One strobe bit per byte lane.

    // AXI response codes. Bit 1 set marks an error.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_issue,
        arb_wait
    } arb_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_stall,
        wr_resp
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_stall,
        rd_data
    } rd_state_e;

endpackage

// ==== design/mem_req_arbiter.sv ====
module mem_req_arbiter (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               a_cs,
    input  logic                               a_we,
    input  logic [mem_axi_pkg::addr_w-1:0]     a_addr,
    input  logic [mem_axi_pkg::strb_w-1:0]     a_byte,
    input  logic [mem_axi_pkg::data_w-1:0]     a_di,
    output logic [mem_axi_pkg::data_w-1:0]     a_do,
    output logic                               a_busy,
    output logic                               a_err,
    input  logic                               b_cs,
    input  logic                               b_we,
    input  logic [mem_axi_pkg::addr_w-1:0]     b_addr,
    input  logic [mem_axi_pkg::strb_w-1:0]     b_byte,
    input  logic [mem_axi_pkg::data_w-1:0]     b_di,
    output logic [mem_axi_pkg::data_w-1:0]     b_do,
    output logic                               b_busy,
    output logic                               b_err,
    output logic                               s_cs,
    output logic                               s_we,
    output logic [mem_axi_pkg::addr_w-1:0]     s_addr,
    output logic [mem_axi_pkg::strb_w-1:0]     s_byte,
    output logic [mem_axi_pkg::data_w-1:0]     s_di,
    input  logic [mem_axi_pkg::data_w-1:0]     s_do,
    input  logic                               s_busy,
    input  logic                               s_err
);

    mem_axi_pkg::arb_state_e state;

    logic [1:0]                     cs_in, we_in, we_q, pend, busy_q, err_q;
    logic [mem_axi_pkg::addr_w-1:0] addr_in [2];
    logic [mem_axi_pkg::addr_w-1:0] addr_q  [2];
    logic [mem_axi_pkg::strb_w-1:0] byte_in [2];
    logic [mem_axi_pkg::strb_w-1:0] byte_q  [2];
    logic [mem_axi_pkg::data_w-1:0] di_in   [2];
    logic [mem_axi_pkg::data_w-1:0] di_q    [2];
    logic [mem_axi_pkg::data_w-1:0] do_q    [2];
    logic                           owner;      // 0 is client a, 1 is client b.
    logic                           rr_ptr;     // Client that wins the next tie.
    logic                           pick;
    logic                           wait_skip;
    logic                           done;

    assign cs_in   = {b_cs, a_cs};
    assign we_in   = {b_we, a_we};
    assign addr_in = '{a_addr, b_addr};
    assign byte_in = '{a_byte, b_byte};
    assign di_in   = '{a_di, b_di};

    assign pick = pend[1] && (!pend[0] || rr_ptr);
    assign done = (state == mem_axi_pkg::arb_wait) && !wait_skip && !s_busy;

    assign s_cs   = (state == mem_axi_pkg::arb_issue);
    assign s_we   = we_q[owner];
    assign s_addr = addr_q[owner];
    assign s_byte = byte_q[owner];
    assign s_di   = di_q[owner];

    assign a_do   = do_q[0];
    assign b_do   = do_q[1];
    assign a_busy = busy_q[0];
    assign b_busy = busy_q[1];
    assign a_err  = err_q[0];
    assign b_err  = err_q[1];

    always_ff @(posedge aclk) begin
        for (int i = 0; i < 2; i++) begin
            if (cs_in[i]) begin
                we_q[i]   <= we_in[i];
                addr_q[i] <= addr_in[i];
                byte_q[i] <= byte_in[i];
                di_q[i]   <= di_in[i];
            end
        end
        if (done && !we_q[owner]) begin
            do_q[owner] <= s_do;  // Writes leave the last read data in place.
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= mem_axi_pkg::arb_idle;
            pend      <= '0;
            busy_q    <= '0;
            err_q     <= '0;
            owner     <= 1'b0;
            rr_ptr    <= 1'b0;
            wait_skip <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cs_in[i]) begin
                    pend[i]   <= 1'b1;
                    busy_q[i] <= 1'b1;
                end
            end
            case (state)
                mem_axi_pkg::arb_idle: begin
                    if (|pend) begin
                        owner <= pick;
                        state <= mem_axi_pkg::arb_issue;
                        if (&pend) begin
                            rr_ptr <= !rr_ptr;  // Only a tie moves the pointer.
                        end
                    end
                end
                mem_axi_pkg::arb_issue: begin
                    wait_skip <= 1'b1;  // Bridge busy is not up until the next edge.
                    state     <= mem_axi_pkg::arb_wait;
                end
                default: begin
                    wait_skip <= 1'b0;
                    if (done) begin
                        pend[owner]   <= 1'b0;
                        busy_q[owner] <= 1'b0;
                        err_q[owner]  <= s_err;
                        state         <= mem_axi_pkg::arb_idle;
                    end
                end
            endcase
        end
    end

    // The bridge takes a strobe only when idle, and never on two cycles in a row.
    a_cs_idle: assert property (@(posedge aclk) disable iff (!aresetn) s_cs |-> !s_busy);
    a_cs_once: assert property (@(posedge aclk) disable iff (!aresetn) s_cs |=> !s_cs);

endmodule

// ==== design/mem2axi_bridge.sv ====
module mem2axi_bridge (
    input  logic                               aclk,
    input  logic                               aresetn,

    input  logic                               s_cs,
    input  logic                               s_we,
    input  logic [mem_axi_pkg::addr_w-1:0]     s_addr,
    input  logic [mem_axi_pkg::strb_w-1:0]     s_byte,
    input  logic [mem_axi_pkg::data_w-1:0]     s_di,
    output logic [mem_axi_pkg::data_w-1:0]     s_do,
    output logic                               s_busy,
    output logic                               s_err,

    output logic [mem_axi_pkg::addr_w-1:0]     m_awaddr,
    output logic                               m_awvalid,
    input  logic                               m_awready,
    output logic [mem_axi_pkg::data_w-1:0]     m_wdata,
    output logic [mem_axi_pkg::strb_w-1:0]     m_wstrb,
    output logic                               m_wvalid,
    input  logic                               m_wready,
    input  mem_axi_pkg::axi_resp_e             m_bresp,
    input  logic                               m_bvalid,
    output logic                               m_bready,
    output logic [mem_axi_pkg::addr_w-1:0]     m_araddr,
    output logic                               m_arvalid,
    input  logic                               m_arready,
    input  logic [mem_axi_pkg::data_w-1:0]     m_rdata,
    input  mem_axi_pkg::axi_resp_e             m_rresp,
    input  logic                               m_rvalid,
    output logic                               m_rready
);

    logic b_hs;
    logic r_hs;

    assign b_hs     = m_bvalid & m_bready;
    assign r_hs     = m_rvalid & m_rready;
    assign m_bready = 1'b1;  // Responses are always taken at once.

    // Request fields follow the strobe side until the access starts.
    always_ff @(posedge aclk) begin
        if (!s_busy) begin
            m_awaddr <= s_addr;
            m_araddr <= s_addr;
            m_wdata  <= s_di;
            m_wstrb  <= s_byte;
        end
        if (r_hs) begin
            s_do <= m_rdata;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s_busy <= 1'b0;
            s_err  <= 1'b0;
        end else begin
            s_busy <= s_cs ? 1'b1 :
                      b_hs ? 1'b0 :
                      r_hs ? 1'b0 :
                             s_busy;
            s_err  <= b_hs ? m_bresp[1] :
                      r_hs ? m_rresp[1] :
                             s_err;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
            m_arvalid <= 1'b0;
        end else if (!s_busy) begin
            m_awvalid <= s_cs & s_we;
            m_wvalid  <= s_cs & s_we;
            m_arvalid <= s_cs & ~s_we;
        end else begin
            if (m_awready) begin
                m_awvalid <= 1'b0;
            end
            if (m_wready) begin
                m_wvalid <= 1'b0;
            end
            if (m_arready) begin
                m_arvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_rready <= 1'b0;
        end else if (m_arvalid & m_arready) begin
            m_rready <= 1'b1;
        end else if (r_hs) begin
            m_rready <= 1'b0;  // Single beat, so the first R ends the read.
        end
    end

    property p_valid_hold(logic valid, logic ready);
        @(posedge aclk) disable iff (!aresetn) valid && !ready |=> valid;
    endproperty

    a_aw_hold: assert property (p_valid_hold(m_awvalid, m_awready));
    a_w_hold:  assert property (p_valid_hold(m_wvalid, m_wready));
    a_ar_hold: assert property (p_valid_hold(m_arvalid, m_arready));

    // A write and a read are never presented together.
    a_one_dir: assert property (@(posedge aclk) disable iff (!aresetn)
        !(m_awvalid && m_arvalid));

endmodule

// ==== design/axi_ram_slave.sv ====
module axi_ram_slave #(
    parameter int mem_depth    = 256,
    parameter int stall_cycles = 2
) (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic [mem_axi_pkg::addr_w-1:0]     m_awaddr,
    input  logic                               m_awvalid,
    output logic                               m_awready,
    input  logic [mem_axi_pkg::data_w-1:0]     m_wdata,
    input  logic [mem_axi_pkg::strb_w-1:0]     m_wstrb,
    input  logic                               m_wvalid,
    output logic                               m_wready,
    output mem_axi_pkg::axi_resp_e             m_bresp,
    output logic                               m_bvalid,
    input  logic                               m_bready,
    input  logic [mem_axi_pkg::addr_w-1:0]     m_araddr,
    input  logic                               m_arvalid,
    output logic                               m_arready,
    output logic [mem_axi_pkg::data_w-1:0]     m_rdata,
    output mem_axi_pkg::axi_resp_e             m_rresp,
    output logic                               m_rvalid,
    input  logic                               m_rready
);

    localparam int idx_w  = $clog2(mem_depth);
    localparam int widx_w = mem_axi_pkg::addr_w - 2;  // Word index bits of a byte address.
    localparam int cnt_w  = $clog2(stall_cycles + 2);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(stall_cycles);

    logic [mem_axi_pkg::data_w-1:0] mem [mem_depth];

    mem_axi_pkg::wr_state_e         wr_state;
    mem_axi_pkg::rd_state_e         rd_state;
    logic [cnt_w-1:0]               wr_cnt, rd_cnt;
    logic                           aw_got, w_got;
    logic                           aw_hs, w_hs, ar_hs, wr_ok, rd_ok;
    logic [mem_axi_pkg::addr_w-1:0] aw_addr_q;
    logic [mem_axi_pkg::data_w-1:0] w_data_q;
    logic [mem_axi_pkg::strb_w-1:0] w_strb_q;

    // Ready opens once the stall count is used up and stays open until accepted.
    assign m_awready = (wr_state != mem_axi_pkg::wr_resp) && (wr_cnt == cnt_max) && !aw_got;
    assign m_wready  = (wr_state != mem_axi_pkg::wr_resp) && (wr_cnt == cnt_max) && !w_got;
    assign m_arready = (rd_state != mem_axi_pkg::rd_data) && (rd_cnt == cnt_max);
    assign aw_hs     = m_awvalid & m_awready;
    assign w_hs      = m_wvalid & m_wready;
    assign ar_hs     = m_arvalid & m_arready;

    assign wr_ok    = aw_addr_q[mem_axi_pkg::addr_w-1:2] < widx_w'(mem_depth);
    assign rd_ok    = m_araddr[mem_axi_pkg::addr_w-1:2] < widx_w'(mem_depth);
    assign m_bvalid = (wr_state == mem_axi_pkg::wr_resp);
    assign m_bresp  = wr_ok ? mem_axi_pkg::resp_okay : mem_axi_pkg::resp_slverr;
    assign m_rvalid = (rd_state == mem_axi_pkg::rd_data);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_state <= mem_axi_pkg::wr_idle;
            wr_cnt   <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else if (wr_state == mem_axi_pkg::wr_resp) begin
            if (m_bready) begin
                wr_state <= mem_axi_pkg::wr_idle;
            end
        end else if ((aw_got | aw_hs) && (w_got | w_hs)) begin
            wr_state <= mem_axi_pkg::wr_resp;
            wr_cnt   <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            aw_got <= aw_got | aw_hs;
            w_got  <= w_got | w_hs;
            if (m_awvalid | m_wvalid) begin
                wr_state <= mem_axi_pkg::wr_stall;
                if (wr_cnt != cnt_max) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            aw_addr_q <= m_awaddr;
        end
        if (w_hs) begin
            w_data_q <= m_wdata;
            w_strb_q <= m_wstrb;
        end
    end

    // The stored word is updated as the response is taken. Out of range writes are dropped.
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (m_bvalid && m_bready && wr_ok) begin
            for (int b = 0; b < mem_axi_pkg::strb_w; b++) begin
                if (w_strb_q[b]) begin
                    mem[aw_addr_q[idx_w+1:2]][8*b +: 8] <= w_data_q[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_state <= mem_axi_pkg::rd_idle;
            rd_cnt   <= '0;
        end else if (rd_state == mem_axi_pkg::rd_data) begin
            if (m_rready) begin
                rd_state <= mem_axi_pkg::rd_idle;
            end
        end else if (ar_hs) begin
            rd_state <= mem_axi_pkg::rd_data;
            rd_cnt   <= '0;
        end else if (m_arvalid) begin
            rd_state <= mem_axi_pkg::rd_stall;
            if (rd_cnt != cnt_max) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            m_rdata <= rd_ok ? mem[m_araddr[idx_w+1:2]] : '0;
            m_rresp <= rd_ok ? mem_axi_pkg::resp_okay : mem_axi_pkg::resp_slverr;
        end
    end

    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_bvalid && !m_bready |=> m_bvalid);

endmodule

// ==== design/mem_axi_top.sv ====
module mem_axi_top #(
    parameter int mem_depth    = 256,
    parameter int stall_cycles = 2
) (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               a_cs,
    input  logic                               a_we,
    input  logic [mem_axi_pkg::addr_w-1:0]     a_addr,
    input  logic [mem_axi_pkg::strb_w-1:0]     a_byte,
    input  logic [mem_axi_pkg::data_w-1:0]     a_di,
    output logic [mem_axi_pkg::data_w-1:0]     a_do,
    output logic                               a_busy,
    output logic                               a_err,
    input  logic                               b_cs,
    input  logic                               b_we,
    input  logic [mem_axi_pkg::addr_w-1:0]     b_addr,
    input  logic [mem_axi_pkg::strb_w-1:0]     b_byte,
    input  logic [mem_axi_pkg::data_w-1:0]     b_di,
    output logic [mem_axi_pkg::data_w-1:0]     b_do,
    output logic                               b_busy,
    output logic                               b_err
);

    // Arbiter to bridge.
    logic                           s_cs, s_we, s_busy, s_err;
    logic [mem_axi_pkg::addr_w-1:0] s_addr;
    logic [mem_axi_pkg::strb_w-1:0] s_byte;
    logic [mem_axi_pkg::data_w-1:0] s_di, s_do;

    // Bridge to RAM slave.
    logic [mem_axi_pkg::addr_w-1:0] m_awaddr, m_araddr;
    logic [mem_axi_pkg::data_w-1:0] m_wdata, m_rdata;
    logic [mem_axi_pkg::strb_w-1:0] m_wstrb;
    logic                           m_awvalid, m_awready, m_wvalid, m_wready;
    logic                           m_bvalid, m_bready, m_arvalid, m_arready;
    logic                           m_rvalid, m_rready;
    mem_axi_pkg::axi_resp_e         m_bresp, m_rresp;

    mem_req_arbiter mem_req_arbiter_inst (.*);

    mem2axi_bridge mem2axi_bridge_inst (.*);

    axi_ram_slave #(
        .mem_depth    (mem_depth),
        .stall_cycles (stall_cycles)
    ) axi_ram_slave_inst (.*);

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 4
) (
    output logic aclk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #1;
        aresetn = 1'b1;  // Released just after the edge, clear of the sampling point.
    end

    always #half_period aclk = ~aclk;

endmodule

// ==== verification/tb_mem_axi.sv ====
module tb_mem_axi;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_depth      = 256;
    localparam int stall_cycles   = 2;
    localparam int idx_w          = $clog2(mem_depth);
    localparam int random_count   = 300;
    localparam int timeout_cycles = 20000;  // About 300 accesses at up to 60 cycles each.
    localparam logic [mem_axi_pkg::strb_w-1:0] full_strb = '1;

    logic                           aclk, aresetn;
    logic                           a_cs, a_we, a_busy, a_err;
    logic                           b_cs, b_we, b_busy, b_err;
    logic [mem_axi_pkg::addr_w-1:0] a_addr, b_addr;
    logic [mem_axi_pkg::strb_w-1:0] a_byte, b_byte;
    logic [mem_axi_pkg::data_w-1:0] a_di, b_di, a_do, b_do;

    logic [mem_axi_pkg::data_w-1:0] model_mem [mem_depth];
    logic [31:0]                    lcg_state = 32'd30319;
    int                             cycle_count = 0;

    tb_clock_gen clock_gen_inst (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    mem_axi_top #(
        .mem_depth    (mem_depth),
        .stall_cycles (stall_cycles)
    ) mem_axi_top_inst (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [mem_axi_pkg::data_w-1:0] exp,
                              input logic [mem_axi_pkg::data_w-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input mem_axi_pkg::axi_resp_e exp,
                              input logic act);
        if (act !== exp[1]) begin
            report_failure($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp[1], act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            report_failure("Timeout: the run did not finish within the cycle limit.");
        end
    end

    // Reference RAM. Out of range words answer SLVERR and read as zero.
    task automatic model_access(input logic we, input logic [mem_axi_pkg::addr_w-1:0] addr,
                                input logic [mem_axi_pkg::strb_w-1:0] strb,
                                input logic [mem_axi_pkg::data_w-1:0] data,
                                output logic [mem_axi_pkg::data_w-1:0] exp_data,
                                output mem_axi_pkg::axi_resp_e exp_resp);
        logic [idx_w-1:0] idx;
        idx = addr[idx_w+1:2];
        if ((addr >> 2) >= 32'(mem_depth)) begin
            exp_resp = mem_axi_pkg::resp_slverr;
            exp_data = '0;
        end else begin
            exp_resp = mem_axi_pkg::resp_okay;
            if (we) begin
                for (int b = 0; b < mem_axi_pkg::strb_w; b++) begin
                    if (strb[b]) begin
                        model_mem[idx][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
            exp_data = model_mem[idx];
        end
    endtask

    task automatic drive_request(input logic client, input logic we,
                                 input logic [mem_axi_pkg::addr_w-1:0] addr,
                                 input logic [mem_axi_pkg::strb_w-1:0] strb,
                                 input logic [mem_axi_pkg::data_w-1:0] data);
        if (client == 1'b0) begin
            a_cs   = 1'b1;
            a_we   = we;
            a_addr = addr;
            a_byte = strb;
            a_di   = data;
        end else begin
            b_cs   = 1'b1;
            b_we   = we;
            b_addr = addr;
            b_byte = strb;
            b_di   = data;
        end
    endtask

    // Ends the one-cycle strobe; busy must be up from this edge on.
    task automatic release_strobes();
        @(posedge aclk);
        #1;
        a_cs = 1'b0;
        b_cs = 1'b0;
    endtask

    task automatic check_result(input logic client, input logic we,
                                input logic [mem_axi_pkg::data_w-1:0] exp_data,
                                input mem_axi_pkg::axi_resp_e exp_resp);
        if (!we) begin
            check_data(client ? "b_do" : "a_do", exp_data, client ? b_do : a_do);
        end
        check_resp(client ? "b_err" : "a_err", exp_resp, client ? b_err : a_err);
    endtask

    task automatic run_access(input logic client, input logic we,
                              input logic [mem_axi_pkg::addr_w-1:0] addr,
                              input logic [mem_axi_pkg::strb_w-1:0] strb,
                              input logic [mem_axi_pkg::data_w-1:0] data);
        logic [mem_axi_pkg::data_w-1:0] exp_data;
        mem_axi_pkg::axi_resp_e         exp_resp;
        model_access(we, addr, strb, data, exp_data, exp_resp);
        drive_request(client, we, addr, strb, data);
        release_strobes();
        check_flag(client ? "b_busy" : "a_busy", 1'b1, client ? b_busy : a_busy);
        while (client ? b_busy : a_busy) begin
            @(posedge aclk);
            #1;
        end
        check_result(client, we, exp_data, exp_resp);
    endtask

    // Both clients strobe together; exp_first names the client that must finish first.
    task automatic run_pair(input logic we, input logic [mem_axi_pkg::addr_w-1:0] addr_a,
                            input logic [mem_axi_pkg::addr_w-1:0] addr_b,
                            input logic [mem_axi_pkg::data_w-1:0] data_a,
                            input logic [mem_axi_pkg::data_w-1:0] data_b,
                            input logic exp_first);
        logic [mem_axi_pkg::data_w-1:0] exp_a, exp_b;
        mem_axi_pkg::axi_resp_e         resp_a, resp_b;
        int                             t_a, t_b, t;
        model_access(we, addr_a, full_strb, data_a, exp_a, resp_a);
        model_access(we, addr_b, full_strb, data_b, exp_b, resp_b);
        drive_request(1'b0, we, addr_a, full_strb, data_a);
        drive_request(1'b1, we, addr_b, full_strb, data_b);
        release_strobes();
        check_flag("a_busy", 1'b1, a_busy);
        check_flag("b_busy", 1'b1, b_busy);
        t_a = -1;
        t_b = -1;
        t   = 0;
        while (t_a < 0 || t_b < 0) begin
            @(posedge aclk);
            #1;
            t++;
            if (!a_busy && t_a < 0) begin
                t_a = t;
            end
            if (!b_busy && t_b < 0) begin
                t_b = t;
            end
        end
        if ((t_b < t_a) != exp_first) begin
            report_failure($sformatf("Simultaneous requests finished in the wrong order: %s",
                $sformatf("client a at cycle %0d, client b at cycle %0d.", t_a, t_b)));
        end
        check_result(1'b0, we, exp_a, resp_a);
        check_result(1'b1, we, exp_b, resp_b);
    endtask

    task automatic test_reset();
        check_flag("a_busy", 1'b0, a_busy);
        check_flag("b_busy", 1'b0, b_busy);
        check_resp("a_err", mem_axi_pkg::resp_okay, a_err);
        check_resp("b_err", mem_axi_pkg::resp_okay, b_err);
    endtask

    task automatic test_byte_strobe();
        run_access(1'b0, 1'b1, 32'h10, full_strb, 32'ha1b2c3d4);
        run_access(1'b1, 1'b1, 32'h10, 4'b0101, 32'h11223344);  // Bytes 0 and 2 only.
        run_access(1'b0, 1'b0, 32'h10, full_strb, '0);
        run_access(1'b1, 1'b0, 32'h10, full_strb, '0);
    endtask

    task automatic test_out_of_range();
        run_access(1'b0, 1'b1, 32'(mem_depth) << 2, full_strb, 32'hdeadbeef);
        run_access(1'b0, 1'b0, (32'(mem_depth) + 32'd5) << 2, full_strb, '0);
        run_access(1'b0, 1'b0, 32'h10, full_strb, '0);  // Error flag must clear again.
    endtask

    task automatic test_simultaneous();
        run_pair(1'b1, 32'h30, 32'h34, 32'hcafe0030, 32'hbeef0034, 1'b0);
        run_pair(1'b0, 32'h34, 32'h30, '0, '0, 1'b1);
    endtask

    task automatic test_random();
        logic [31:0] r, s, word;
        for (int n = 0; n < random_count; n++) begin
            r = lcg_next();
            s = lcg_next();
            if (r[29:27] == 3'd0) begin
                word = 32'(mem_depth) + ((r >> 16) & 32'h3f);
            end else begin
                word = (r >> 16) & 32'h3f;  // A small window so reads hit written words.
            end
            run_access(r[31], r[30], word << 2, s[19:16], lcg_next());
        end
    endtask

    initial begin
        a_cs   = 1'b0;
        a_we   = 1'b0;
        a_addr = '0;
        a_byte = '0;
        a_di   = '0;
        b_cs   = 1'b0;
        b_we   = 1'b0;
        b_addr = '0;
        b_byte = '0;
        b_di   = '0;
        for (int i = 0; i < mem_depth; i++) begin
            model_mem[i] = '0;
        end
        wait (aresetn === 1'b1);
        @(posedge aclk);
        #1;
        test_reset();
        test_byte_strobe();
        test_out_of_range();
        test_simultaneous();
        test_random();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/mem_axi_pkg.sv
design/mem_req_arbiter.sv
design/mem2axi_bridge.sv
design/axi_ram_slave.sv
design/mem_axi_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_axi.sv

// ==== Makefile ====
# Verilator build and run for the memory to AXI subsystem.

VERILATOR  ?= verilator
TOP        ?= tb_mem_axi
RTL_TOP    ?= mem_axi_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
